//--- src/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

  // ------------------------------------------------------------------------
  // Basic vector types
  // ------------------------------------------------------------------------
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [15:0] count_t;

  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned INST_BYTES = 4;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;

  // Funct3 of the checked instructions
  localparam logic [2:0] F3_ANDI = 3'b111;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_LBU  = 3'b100;

  // ------------------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    ERR_FLOW,
    ERR_DEST,
    ERR_VALUE
  } err_kind_e;

  typedef enum logic [1:0] {
    RPT_IDLE,
    RPT_REQ,
    RPT_DRAIN
  } report_state_e;

  // ------------------------------------------------------------------------
  // Records
  // ------------------------------------------------------------------------
  // One retired instruction as seen at writeback
  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    inst_t    inst;
    logic     we;
    reg_idx_t rd;
    xlen_t    value;
    xlen_t    load_word;
  } commit_t;

  typedef struct packed {
    logic      hit;
    err_kind_e kind;
    xlen_t     pc;
  } mismatch_t;

  typedef struct packed {
    err_kind_e kind;
    xlen_t     pc;
    count_t    index;
    logic      lost;
  } err_rec_t;

  typedef struct packed {
    count_t retired;
    count_t checked;
  } stats_t;

endpackage

`default_nettype wire

//--- src/shadow_regfile.sv
`default_nettype none

module shadow_regfile (
  input  wire              clk,
  input  wire              rst_n,
  input  rvc_pkg::commit_t  commit_i,
  input  rvc_pkg::reg_idx_t rs1_idx_i,
  input  rvc_pkg::reg_idx_t rs2_idx_i,
  output rvc_pkg::xlen_t    rs1_val_o,
  output rvc_pkg::xlen_t    rs2_val_o
);

  rvc_pkg::xlen_t regs_q [rvc_pkg::NUM_REGS];
  logic           wr_en;

  // x0 is never written
  assign wr_en = commit_i.valid && commit_i.we && (commit_i.rd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rvc_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[commit_i.rd] <= commit_i.value;
    end
  end

  // Reads see the state before this commit's own write
  assign rs1_val_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_val_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

endmodule

`default_nettype wire

//--- src/commit_golden.sv
`default_nettype none

module commit_golden (
  input  wire                clk,
  input  wire                rst_n,
  input  rvc_pkg::commit_t   commit_i,
  input  rvc_pkg::xlen_t     rs1_val_i,
  input  rvc_pkg::xlen_t     rs2_val_i,
  output rvc_pkg::reg_idx_t  rs1_idx_o,
  output rvc_pkg::reg_idx_t  rs2_idx_o,
  output logic               checked_o,
  output rvc_pkg::mismatch_t mismatch_o
);

  // --------------------------------------------------------------------------
  // Field extraction
  // --------------------------------------------------------------------------
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  rvc_pkg::reg_idx_t rd_field;
  rvc_pkg::xlen_t    imm_i;
  rvc_pkg::xlen_t    imm_u;
  rvc_pkg::xlen_t    imm_j;
  rvc_pkg::xlen_t    imm_b;
  rvc_pkg::xlen_t    pc_step;

  assign opcode    = commit_i.inst[6:0];
  assign funct3    = commit_i.inst[14:12];
  assign rd_field  = commit_i.inst[11:7];
  assign rs1_idx_o = commit_i.inst[19:15];
  assign rs2_idx_o = commit_i.inst[24:20];

  assign imm_i = {{20{commit_i.inst[31]}}, commit_i.inst[31:20]};
  assign imm_u = {commit_i.inst[31:12], 12'b0};
  assign imm_j = {{12{commit_i.inst[31]}}, commit_i.inst[19:12], commit_i.inst[20],
                  commit_i.inst[30:21], 1'b0};
  assign imm_b = {{20{commit_i.inst[31]}}, commit_i.inst[7], commit_i.inst[30:25],
                  commit_i.inst[11:8], 1'b0};

  assign pc_step = commit_i.pc + rvc_pkg::xlen_t'(rvc_pkg::INST_BYTES);

  // Checked instruction decode
  logic is_andi;
  logic is_auipc;
  logic is_jal;
  logic is_bge;
  logic is_lbu;
  logic is_checked;

  assign is_andi    = (opcode == rvc_pkg::OPC_OP_IMM) && (funct3 == rvc_pkg::F3_ANDI);
  assign is_auipc   = (opcode == rvc_pkg::OPC_AUIPC);
  assign is_jal     = (opcode == rvc_pkg::OPC_JAL);
  assign is_bge     = (opcode == rvc_pkg::OPC_BRANCH) && (funct3 == rvc_pkg::F3_BGE);
  assign is_lbu     = (opcode == rvc_pkg::OPC_LOAD) && (funct3 == rvc_pkg::F3_LBU);
  assign is_checked = is_andi || is_auipc || is_jal || is_bge || is_lbu;

  assign checked_o = commit_i.valid && is_checked;

  // --------------------------------------------------------------------------
  // Expected writeback
  // --------------------------------------------------------------------------
  rvc_pkg::xlen_t load_addr;
  rvc_pkg::xlen_t lbu_value;
  rvc_pkg::xlen_t exp_value;
  logic           exp_we;

  assign load_addr = rs1_val_i + imm_i;

  always_comb begin
    case (load_addr[1:0])
      2'b00:   lbu_value = {24'b0, commit_i.load_word[7:0]};
      2'b01:   lbu_value = {24'b0, commit_i.load_word[15:8]};
      2'b10:   lbu_value = {24'b0, commit_i.load_word[23:16]};
      default: lbu_value = {24'b0, commit_i.load_word[31:24]};
    endcase
  end

  always_comb begin
    exp_value = '0;
    if (is_andi) begin
      exp_value = rs1_val_i & imm_i;
    end else if (is_auipc) begin
      exp_value = commit_i.pc + imm_u;
    end else if (is_jal) begin
      exp_value = pc_step;
    end else if (is_lbu) begin
      exp_value = lbu_value;
    end
  end

  // bge has no destination, the rest write rd unless it is x0
  assign exp_we = !is_bge && (rd_field != '0);

  // --------------------------------------------------------------------------
  // Next pc tracking
  // --------------------------------------------------------------------------
  rvc_pkg::xlen_t exp_pc_q;
  logic           exp_pc_known_q;
  rvc_pkg::xlen_t next_pc;
  logic           next_pc_known;
  rvc_pkg::xlen_t jal_target;
  logic           bge_taken;

  assign jal_target = commit_i.pc + imm_j;
  assign bge_taken  = $signed(rs1_val_i) >= $signed(rs2_val_i);

  always_comb begin
    next_pc       = pc_step;
    next_pc_known = 1'b1;
    if (is_jal) begin
      next_pc = {jal_target[31:2], 2'b00};
    end else if (is_bge) begin
      next_pc = bge_taken ? (commit_i.pc + imm_b) : pc_step;
    end else if ((opcode == rvc_pkg::OPC_JALR) || (opcode == rvc_pkg::OPC_BRANCH)) begin
      // Target depends on registers or compares not modelled here
      next_pc_known = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc_known_q <= 1'b0;
    end else if (commit_i.valid) begin
      exp_pc_known_q <= next_pc_known;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_i.valid) begin
      exp_pc_q <= next_pc;
    end
  end

  // --------------------------------------------------------------------------
  // Mismatch classification
  // --------------------------------------------------------------------------
  logic flow_err;
  logic dest_err;
  logic value_err;

  assign flow_err  = exp_pc_known_q && (commit_i.pc != exp_pc_q);
  assign dest_err  = is_checked &&
                     ((commit_i.we != exp_we) || (exp_we && (commit_i.rd != rd_field)));
  assign value_err = is_checked && exp_we && (commit_i.value != exp_value);

  always_comb begin
    mismatch_o.hit  = commit_i.valid && (flow_err || dest_err || value_err);
    mismatch_o.pc   = commit_i.pc;
    mismatch_o.kind = rvc_pkg::ERR_VALUE;
    if (flow_err) begin
      mismatch_o.kind = rvc_pkg::ERR_FLOW;
    end else if (dest_err) begin
      mismatch_o.kind = rvc_pkg::ERR_DEST;
    end
  end

endmodule

`default_nettype wire

//--- src/retire_counter.sv
`default_nettype none

module retire_counter (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             commit_valid_i,
  input  wire             checked_i,
  output rvc_pkg::stats_t stats_o
);

  rvc_pkg::count_t retired_q;
  rvc_pkg::count_t checked_q;

  // Both counters wrap silently
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retired_q <= '0;
      checked_q <= '0;
    end else begin
      if (commit_valid_i) begin
        retired_q <= retired_q + rvc_pkg::count_t'(1);
      end
      if (checked_i) begin
        checked_q <= checked_q + rvc_pkg::count_t'(1);
      end
    end
  end

  // Retired count before increment doubles as index of the current commit
  assign stats_o.retired = retired_q;
  assign stats_o.checked = checked_q;

endmodule

`default_nettype wire

//--- src/report_fsm.sv
`default_nettype none

module report_fsm (
  input  wire                clk,
  input  wire                rst_n,
  input  rvc_pkg::mismatch_t mismatch_i,
  input  rvc_pkg::count_t    index_i,
  input  wire                err_ack_i,
  output logic               err_req_o,
  output rvc_pkg::err_rec_t  err_o
);

  rvc_pkg::report_state_e state_q;
  rvc_pkg::report_state_e state_d;
  rvc_pkg::err_rec_t      rec_q;
  logic                   lost_q;
  logic                   capture;

  // ------------------------------------------------------------------------
  // Four-phase handshake sequencing
  // ------------------------------------------------------------------------
  assign capture = (state_q == rvc_pkg::RPT_IDLE) && mismatch_i.hit;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rvc_pkg::RPT_IDLE:  if (mismatch_i.hit) state_d = rvc_pkg::RPT_REQ;
      rvc_pkg::RPT_REQ:   if (err_ack_i) state_d = rvc_pkg::RPT_DRAIN;
      rvc_pkg::RPT_DRAIN: if (!err_ack_i) state_d = rvc_pkg::RPT_IDLE;
      default:            state_d = rvc_pkg::RPT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= rvc_pkg::RPT_IDLE;
      lost_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        lost_q <= 1'b0;
      end else if (mismatch_i.hit) begin
        // Busy with an earlier report, this one is dropped
        lost_q <= 1'b1;
      end
    end
  end

  // Record only changes while no request is outstanding
  always_ff @(posedge clk) begin
    if (capture) begin
      rec_q.kind  <= mismatch_i.kind;
      rec_q.pc    <= mismatch_i.pc;
      rec_q.index <= index_i;
      rec_q.lost  <= lost_q;
    end
  end

  assign err_req_o = (state_q == rvc_pkg::RPT_REQ);
  assign err_o     = rec_q;

endmodule

`default_nettype wire

//--- src/commit_checker_top.sv
`default_nettype none

module commit_checker_top (
  input  wire               clk,
  input  wire               rst_n,
  input  rvc_pkg::commit_t  commit_i,
  input  wire               err_ack_i,
  output logic              err_req_o,
  output rvc_pkg::err_rec_t err_o,
  output rvc_pkg::stats_t   stats_o
);

  rvc_pkg::reg_idx_t  rs1_idx;
  rvc_pkg::reg_idx_t  rs2_idx;
  rvc_pkg::xlen_t     rs1_val;
  rvc_pkg::xlen_t     rs2_val;
  logic               checked;
  rvc_pkg::mismatch_t mismatch;

  // --------------------------------------------------------------------------
  // Operand mirror and golden check
  // --------------------------------------------------------------------------
  shadow_regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .commit_i  (commit_i),
    .rs1_idx_i (rs1_idx),
    .rs2_idx_i (rs2_idx),
    .rs1_val_o (rs1_val),
    .rs2_val_o (rs2_val)
  );

  commit_golden u_golden (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit_i   (commit_i),
    .rs1_val_i  (rs1_val),
    .rs2_val_i  (rs2_val),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .checked_o  (checked),
    .mismatch_o (mismatch)
  );

  // --------------------------------------------------------------------------
  // Statistics and host reporting
  // --------------------------------------------------------------------------
  retire_counter u_counter (
    .clk            (clk),
    .rst_n          (rst_n),
    .commit_valid_i (commit_i.valid),
    .checked_i      (checked),
    .stats_o        (stats_o)
  );

  // Pre-increment retired count labels the failing commit
  report_fsm u_report (
    .clk        (clk),
    .rst_n      (rst_n),
    .mismatch_i (mismatch),
    .index_i    (stats_o.retired),
    .err_ack_i  (err_ack_i),
    .err_req_o  (err_req_o),
    .err_o      (err_o)
  );

endmodule

`default_nettype wire

//--- testbench/commit_checker_tb.sv
`default_nettype none

module commit_checker_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TEST_CYCLES = 1000;
  localparam int HS_LIMIT    = 20;

  // Instruction selectors for the generator
  localparam int OP_ANDI  = 0;
  localparam int OP_AUIPC = 1;
  localparam int OP_LBU   = 2;
  localparam int OP_ALU   = 3;
  localparam int OP_JAL   = 4;
  localparam int OP_BGE   = 5;
  localparam int OP_JALR  = 6;

  logic              clk = 1'b0;
  logic              rst_n;
  rvc_pkg::commit_t  commit_i;
  logic              err_ack_i;
  logic              err_req_o;
  rvc_pkg::err_rec_t err_o;
  rvc_pkg::stats_t   stats_o;

  commit_checker_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .commit_i  (commit_i),
    .err_ack_i (err_ack_i),
    .err_req_o (err_req_o),
    .err_o     (err_o),
    .stats_o   (stats_o)
  );

  always #50 clk = ~clk;

  // --------------------------------------------------------------------------
  // Reference model state
  // --------------------------------------------------------------------------
  rvc_pkg::xlen_t    m_regs [32];
  rvc_pkg::xlen_t    m_exp_pc;
  logic              m_exp_known;
  rvc_pkg::count_t   m_retired;
  rvc_pkg::count_t   m_checked;
  logic              rpt_busy;
  logic              m_lost;
  rvc_pkg::err_rec_t exp_rec;

  // Correct commit and next pc of the last generated instruction
  rvc_pkg::commit_t  g_commit;
  rvc_pkg::xlen_t    g_next;
  logic              g_known;
  logic              g_checked;
  logic              zero_rs1;

  rvc_pkg::xlen_t    cur_pc;
  int                errors;
  int                test_errors;
  int                tests_passed;
  int                tests_failed;

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_req(input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: err_req_o got %h expected %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_rec(input rvc_pkg::err_rec_t got, input rvc_pkg::err_rec_t exp);
    if (got !== exp) begin
      $display("** Error: err_o kind/pc/index/lost got %h/%h/%h/%h expected %h/%h/%h/%h",
               got.kind, got.pc, got.index, got.lost, exp.kind, exp.pc, exp.index, exp.lost);
      errors++;
    end
  endtask

  task automatic check_stats(input rvc_pkg::stats_t got, input rvc_pkg::stats_t exp);
    if (got !== exp) begin
      $display("** Error: stats_o retired/checked got %h/%h expected %h/%h",
               got.retired, got.checked, exp.retired, exp.checked);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s at %0t", msg, $time);
    errors++;
  endtask

  task automatic compare_counts();
    rvc_pkg::stats_t exp;
    exp.retired = m_retired;
    exp.checked = m_checked;
    check_stats(stats_o, exp);
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      $display("[%s] ok", name);
      tests_passed++;
    end else begin
      $display("[%s] failed with %0d errors", name, errors - test_errors);
      tests_failed++;
    end
    test_errors = errors;
  endtask

  function automatic rvc_pkg::reg_idx_t rand_rd();
    return 5'(($urandom % 31) + 1);
  endfunction

  // --------------------------------------------------------------------------
  // Instruction generator building the correct commit from the ISA rules
  // --------------------------------------------------------------------------
  task automatic gen(input int op, input rvc_pkg::xlen_t pc, input rvc_pkg::reg_idx_t rd,
                     input int off);
    rvc_pkg::reg_idx_t rs1;
    rvc_pkg::reg_idx_t rs2;
    logic [11:0]       imm12;
    logic [19:0]       imm20;
    logic [20:0]       imm21;
    logic [12:0]       imm13;
    rvc_pkg::xlen_t    sext12;
    rvc_pkg::xlen_t    target;
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    imm12 = 12'($urandom);
    imm20 = 20'($urandom);
    imm21 = 21'($urandom);
    imm13 = 13'($urandom);
    imm21[0] = 1'b0;
    imm13[0] = 1'b0;
    if (zero_rs1) begin
      rs1 = '0;
    end
    g_commit = '0;
    g_commit.valid = 1'b1;
    g_commit.pc = pc;
    g_commit.rd = rd;
    g_commit.we = (rd != '0);
    g_commit.load_word = $urandom;
    g_next = pc + 32'd4;
    g_known = 1'b1;
    g_checked = 1'b1;
    case (op)
      OP_ANDI: begin
        sext12 = {{20{imm12[11]}}, imm12};
        g_commit.inst = {imm12, rs1, rvc_pkg::F3_ANDI, rd, rvc_pkg::OPC_OP_IMM};
        g_commit.value = m_regs[rs1] & sext12;
      end
      OP_AUIPC: begin
        g_commit.inst = {imm20, rd, rvc_pkg::OPC_AUIPC};
        g_commit.value = pc + {imm20, 12'h000};
      end
      OP_LBU: begin
        // Steer the low address bits onto the requested byte lane
        if (off >= 0) begin
          imm12[1:0] = 2'(off) - m_regs[rs1][1:0];
        end
        sext12 = {{20{imm12[11]}}, imm12};
        target = m_regs[rs1] + sext12;
        g_commit.inst = {imm12, rs1, rvc_pkg::F3_LBU, rd, rvc_pkg::OPC_LOAD};
        g_commit.value = (g_commit.load_word >> {target[1:0], 3'b000}) & 32'h0000_00ff;
      end
      OP_JAL: begin
        target = pc + {{11{imm21[20]}}, imm21};
        g_commit.inst = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd,
                         rvc_pkg::OPC_JAL};
        g_commit.value = pc + 32'd4;
        g_next = {target[31:2], 2'b00};
      end
      OP_BGE: begin
        g_commit.inst = {imm13[12], imm13[10:5], rs2, rs1, rvc_pkg::F3_BGE, imm13[4:1],
                         imm13[11], rvc_pkg::OPC_BRANCH};
        g_commit.rd = '0;
        g_commit.we = 1'b0;
        if ($signed(m_regs[rs1]) >= $signed(m_regs[rs2])) begin
          g_next = pc + {{19{imm13[12]}}, imm13};
        end
      end
      OP_JALR: begin
        g_commit.inst = {imm12, rs1, 3'b000, rd, rvc_pkg::OPC_JALR};
        g_commit.value = $urandom;
        g_known = 1'b0;
        g_checked = 1'b0;
      end
      default: begin
        // Unchecked register-register add with whatever value the core wrote
        g_commit.inst = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
        g_commit.value = $urandom;
        g_checked = 1'b0;
      end
    endcase
  endtask

  // --------------------------------------------------------------------------
  // Commit driver with model update and report host
  // --------------------------------------------------------------------------
  task automatic send(input rvc_pkg::commit_t c);
    logic              flow;
    logic              dest;
    logic              value;
    rvc_pkg::err_kind_e kind;
    flow  = m_exp_known && (c.pc != m_exp_pc);
    dest  = g_checked && ((c.we != g_commit.we) || (g_commit.we && (c.rd != g_commit.rd)));
    value = g_checked && g_commit.we && (c.value != g_commit.value);
    kind  = flow ? rvc_pkg::ERR_FLOW : (dest ? rvc_pkg::ERR_DEST : rvc_pkg::ERR_VALUE);
    if (flow || dest || value) begin
      if (!rpt_busy) begin
        exp_rec.kind = kind;
        exp_rec.pc = c.pc;
        exp_rec.index = m_retired;
        exp_rec.lost = m_lost;
        m_lost = 1'b0;
        rpt_busy = 1'b1;
      end else begin
        m_lost = 1'b1;
      end
    end
    if (c.we && (c.rd != '0)) begin
      m_regs[c.rd] = c.value;
    end
    m_exp_pc = g_next;
    m_exp_known = g_known;
    m_retired = m_retired + rvc_pkg::count_t'(1);
    if (g_checked) begin
      m_checked = m_checked + rvc_pkg::count_t'(1);
    end
    commit_i = c;
    @(negedge clk);
    commit_i.valid = 1'b0;
    check_req(err_req_o, rpt_busy);
  endtask

  // Idle cycles carry random contents with valid low
  task automatic idle(input int n);
    repeat (n) begin
      commit_i.pc        = $urandom;
      commit_i.inst      = $urandom;
      commit_i.we        = 1'($urandom);
      commit_i.rd        = 5'($urandom);
      commit_i.value     = $urandom;
      commit_i.load_word = $urandom;
      @(negedge clk);
      check_req(err_req_o, rpt_busy);
    end
  endtask

  task automatic serve_report();
    int waited;
    waited = 0;
    if (!rpt_busy) begin
      report_failure("no report is pending in the model");
      return;
    end
    while (err_req_o !== 1'b1 && waited < HS_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (err_req_o !== 1'b1) begin
      report_failure("err_req_o never rose for a pending report");
      return;
    end
    check_rec(err_o, exp_rec);
    err_ack_i = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (err_req_o === 1'b1 && waited < HS_LIMIT);
    if (err_req_o !== 1'b0) begin
      report_failure("err_req_o stayed high after err_ack_i");
    end
    err_ack_i = 1'b0;
    // Drain state returns to idle one edge after the ack drops
    @(negedge clk);
    rpt_busy = 1'b0;
  endtask

  // Watchdog
  initial begin
    #(TEST_CYCLES * 100 * 4);
    $display("Watchdog expired before the tests completed");
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    rvc_pkg::commit_t c;
    rvc_pkg::xlen_t   pc;
    int               op;
    int               sel;
    logic             wrong;
    void'($urandom(49760));
    rst_n = 1'b0;
    commit_i = '0;
    err_ack_i = 1'b0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_exp_pc = '0;
    m_exp_known = 1'b0;
    m_retired = '0;
    m_checked = '0;
    rpt_busy = 1'b0;
    m_lost = 1'b0;
    exp_rec = '0;
    zero_rs1 = 1'b0;
    cur_pc = 32'h0000_1000;
    errors = 0;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_req(err_req_o, 1'b0);
    compare_counts();

    // Clean stream after seeding the registers through unchecked writes
    for (int i = 1; i < 32; i++) begin
      gen(OP_ALU, cur_pc, 5'(i), -1);
      send(g_commit);
      cur_pc = g_next;
    end
    for (int i = 0; i < 150; i++) begin
      gen(int'($urandom % 4), cur_pc, rand_rd(), -1);
      send(g_commit);
      cur_pc = g_next;
    end
    compare_counts();
    finish_test("clean_stream");

    // Corrupted value, rd or we
    for (int k = 0; k < 6; k++) begin
      gen(k % 3, cur_pc, rand_rd(), -1);
      c = g_commit;
      case ((k / 2) % 3)
        0:       c.value = c.value ^ (32'h1 << 5'($urandom));
        1:       c.rd = c.rd ^ 5'(($urandom % 31) + 1);
        default: c.we = 1'b0;
      endcase
      send(c);
      cur_pc = g_next;
      serve_report();
    end
    compare_counts();
    finish_test("corrupt_writeback");

    // Control flow after jal, bge and jalr
    for (int i = 0; i < 40; i++) begin
      sel = int'($urandom % 3);
      op = (sel == 0) ? OP_JAL : ((sel == 1) ? OP_BGE : OP_JALR);
      gen(op, cur_pc, rand_rd(), -1);
      send(g_commit);
      wrong = (op != OP_JALR) && ($urandom % 2 == 1);
      if (op == OP_JALR) begin
        pc = $urandom & 32'hffff_fffc;
      end else begin
        pc = wrong ? (g_next ^ 32'h0000_0010) : g_next;
      end
      gen(OP_ANDI, pc, rand_rd(), -1);
      send(g_commit);
      cur_pc = g_next;
      if (wrong) begin
        serve_report();
      end
    end
    compare_counts();
    finish_test("control_flow");

    // Second fault lands while the first is still reported
    gen(OP_ANDI, cur_pc, rand_rd(), -1);
    c = g_commit;
    c.value = ~c.value;
    send(c);
    cur_pc = g_next;
    gen(OP_AUIPC, cur_pc, rand_rd(), -1);
    c = g_commit;
    c.value = ~c.value;
    send(c);
    cur_pc = g_next;
    serve_report();
    gen(OP_ANDI, cur_pc, rand_rd(), -1);
    send(g_commit);
    cur_pc = g_next;
    gen(OP_LBU, cur_pc, rand_rd(), -1);
    c = g_commit;
    c.value = ~c.value;
    send(c);
    cur_pc = g_next;
    serve_report();
    finish_test("lost_report");

    // Byte lanes of lbu, then x0 handling
    for (int off = 0; off < 4; off++) begin
      repeat (2) begin
        gen(OP_LBU, cur_pc, rand_rd(), off);
        send(g_commit);
        cur_pc = g_next;
      end
    end
    gen(OP_ALU, cur_pc, 5'd0, -1);
    c = g_commit;
    c.we = 1'b1;
    send(c);
    cur_pc = g_next;
    zero_rs1 = 1'b1;
    gen(OP_ANDI, cur_pc, rand_rd(), -1);
    send(g_commit);
    cur_pc = g_next;
    gen(OP_LBU, cur_pc, rand_rd(), -1);
    send(g_commit);
    cur_pc = g_next;
    zero_rs1 = 1'b0;
    gen(OP_ANDI, cur_pc, 5'd0, -1);
    send(g_commit);
    cur_pc = g_next;
    compare_counts();
    finish_test("lbu_lanes_x0");

    // Idle gaps between commits
    for (int i = 0; i < 80; i++) begin
      gen(int'($urandom % 6), cur_pc, 5'($urandom), -1);
      send(g_commit);
      cur_pc = g_next;
      idle(int'($urandom % 4));
    end
    compare_counts();
    finish_test("idle_gaps");

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
src/rvc_pkg.sv
src/shadow_regfile.sv
src/commit_golden.sv
src/retire_counter.sv
src/report_fsm.sv
src/commit_checker_top.sv
testbench/commit_checker_tb.sv

//--- Makefile
# Verilator build for the commit checker testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f list.f --top-module commit_checker_tb -Mdir obj_dir

run: compile
	./obj_dir/Vcommit_checker_tb | tee run.log
	grep -q "STATUS: PASS" run.log

clean:
	rm -rf obj_dir run.log
